// File: logic/st_audio_pkg.sv
// ========================================
// widths and limits of the st sound path
// mix samples are 15-bit two's complement
// ========================================

package st_audio_pkg;

	// psg side
	localparam int ym_level_w = 8;	// one channel level from the ym2149
	localparam int ym_sum_w   = 10;	// three levels summed, no overflow
	localparam int ym_mid     = 512;	// midpoint of a 10-bit sum

	// ste dma sound side
	localparam int dma_w   = 8;	// shifter sample, offset binary
	localparam int dma_mid = 128;

	// common scale for the mixer and the dac
	localparam int mix_w = 15;
	localparam int signed mix_max = (1 << (mix_w - 1)) - 1;	// 16383
	localparam int signed mix_min = -(1 << (mix_w - 1));	// -16384

	// 32 MHz / 16 gives the 2 MHz psg enable
	localparam int ce2_div = 16;

	// 74ls164 style delay before timer a
	localparam int irq_stages = 8;

	// raw psg sums, unsigned
	typedef struct packed {
		logic [ym_sum_w-1:0] left;
		logic [ym_sum_w-1:0] right;
	} ym_stereo_t;

	// dma sound pair as it leaves the shifter
	typedef struct packed {
		logic [dma_w-1:0] left;
		logic [dma_w-1:0] right;
	} dma_stereo_t;

	// widened or mixed pair, signed
	typedef struct packed {
		logic signed [mix_w-1:0] left;
		logic signed [mix_w-1:0] right;
	} mix_stereo_t;

endpackage

// File: logic/psg_channel_mix.sv
// ========================================
// channel levels must be held in clk_32
// ========================================

module psg_channel_mix (
	input  logic                               clk_32,
	input  logic                               xsint,		// async, active low
	input  logic [st_audio_pkg::ym_level_w-1:0] ym_a_i,
	input  logic [st_audio_pkg::ym_level_w-1:0] ym_b_i,
	input  logic [st_audio_pkg::ym_level_w-1:0] ym_c_i,
	input  logic                               psg_stereo_i,	// 1: a+b / c+b
	output st_audio_pkg::ym_stereo_t           ym_o
);
	import st_audio_pkg::*;

	logic [ym_sum_w-1:0] lvl_a;
	logic [ym_sum_w-1:0] lvl_b;
	logic [ym_sum_w-1:0] lvl_c;
	logic [ym_sum_w-1:0] sum_ab;
	logic [ym_sum_w-1:0] sum_cb;
	logic [ym_sum_w-1:0] sum_abc;
	ym_stereo_t          ym_q;

	// zero extend first so the sums keep every carry
	assign lvl_a = ym_sum_w'(ym_a_i);
	assign lvl_b = ym_sum_w'(ym_b_i);
	assign lvl_c = ym_sum_w'(ym_c_i);

	assign sum_ab  = lvl_a + lvl_b;
	assign sum_cb  = lvl_c + lvl_b;	// b sits in the middle of the stage
	assign sum_abc = sum_ab + lvl_c;	// max 765, fits in 10 bits

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ym_q <= '0;
		end else if (psg_stereo_i) begin
			ym_q.left  <= sum_ab;
			ym_q.right <= sum_cb;
		end else begin
			// mono, same sum on both sides
			ym_q.left  <= sum_abc;
			ym_q.right <= sum_abc;
		end
	end

	assign ym_o = ym_q;

endmodule

// File: logic/sample_expand.sv
// ========================================
// payload is a two-field struct, 8 to 14
// bits per field, offset binary in
// ========================================

module sample_expand #(
	parameter type stereo_t = st_audio_pkg::ym_stereo_t
) (
	input  stereo_t                    pair_i,	// unsigned, midpoint is silence
	output st_audio_pkg::mix_stereo_t  pair_o
);
	import st_audio_pkg::*;

	localparam int field_w = $bits(stereo_t) / 2;

	// offset follows the field width
	localparam int mid = 1 << (field_w - 1);

	// the replication below needs at least 7 bits and no more than mix_w-1
	if (field_w < 8 || field_w > 14) begin : g_width_check
		$error("sample_expand: field width %0d outside 8..14", field_w);
	end

	// offset binary to signed, then stretch to mix_w by repeating the sample
	// below itself, so full scale lands near full scale
	function automatic logic signed [mix_w-1:0] widen(input logic [field_w-1:0] raw);
		logic signed [field_w-1:0] s;
		logic [2*field_w-1:0]      tile;
		s    = raw - field_w'(mid);	// flips the msb in effect
		tile = {s, s};
		widen = {s[field_w-1], tile[2*field_w-1 -: mix_w-1]};	// sign, sample, top bits
	endfunction

	// 10 bit: {s9, s, s[9:6]}
	// 8 bit:  {s7, s, s[7:2]}
	assign pair_o.left  = widen(pair_i.left);
	assign pair_o.right = widen(pair_i.right);

endmodule

// File: logic/audio_mixer.sv
// ========================================
// saturates, unlike the wrapping st sum
// ========================================

module audio_mixer (
	input  logic                      clk_32,
	input  logic                      xsint,	// async, active low
	input  st_audio_pkg::mix_stereo_t ym_i,		// widened psg pair
	input  st_audio_pkg::mix_stereo_t dma_i,	// widened dma pair
	output st_audio_pkg::mix_stereo_t mix_o
);
	import st_audio_pkg::*;

	logic signed [mix_w:0] sum_l;	// one guard bit
	logic signed [mix_w:0] sum_r;
	mix_stereo_t           mix_q;

	function automatic logic signed [mix_w-1:0] clamp(input logic signed [mix_w:0] s);
		if (s > mix_max)
			clamp = mix_w'(mix_max);
		else if (s < mix_min)
			clamp = mix_w'(mix_min);
		else
			clamp = s[mix_w-1:0];	// guard bit equals sign here
	endfunction

	assign sum_l = ym_i.left + dma_i.left;	// both signed, extends
	assign sum_r = ym_i.right + dma_i.right;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_q <= '0;
		end else begin
			mix_q.left  <= clamp(sum_l);
			mix_q.right <= clamp(sum_r);
		end
	end

	assign mix_o = mix_q;

	// an overflowing sum must land exactly on the rail, never wrap
	a_sat_hi_l: assert property (@(posedge clk_32) disable iff (!xsint)
		(sum_l > mix_max) |=> (mix_q.left == mix_max));
	a_sat_lo_l: assert property (@(posedge clk_32) disable iff (!xsint)
		(sum_l < mix_min) |=> (mix_q.left == mix_min));
	a_sat_hi_r: assert property (@(posedge clk_32) disable iff (!xsint)
		(sum_r > mix_max) |=> (mix_q.right == mix_max));
	a_sat_lo_r: assert property (@(posedge clk_32) disable iff (!xsint)
		(sum_r < mix_min) |=> (mix_q.right == mix_min));

endmodule

// File: logic/sigma_delta_dac.sv
// ========================================
// first order, one bit per clk_32 cycle
// needs an external rc low-pass
// ========================================

module sigma_delta_dac (
	input  logic                                 clk_32,
	input  logic                                 xsint,		// async, active low
	input  logic signed [st_audio_pkg::mix_w-1:0] sample_i,	// two's complement
	output logic                                 bit_o		// pdm bitstream
);
	import st_audio_pkg::*;

	logic [mix_w-1:0] level;	// offset binary, 0..32767
	logic [mix_w:0]   acc_sum;	// carry in the msb
	logic [mix_w-1:0] acc_q;
	logic             bit_q;

	// sign flip, so -16384 is silence at the bottom rail
	assign level = {~sample_i[mix_w-1], sample_i[mix_w-2:0]};

	// remainder stays in acc_q, which is the first order error feedback
	// count of ones in any window is within one of level/32768 * length
	assign acc_sum = {1'b0, acc_q} + {1'b0, level};

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			acc_q <= '0;
			bit_q <= 1'b0;
		end else begin
			acc_q <= acc_sum[mix_w-1:0];
			bit_q <= acc_sum[mix_w];	// carry out is the output bit
		end
	end

	assign bit_o = bit_q;

endmodule

// File: logic/sound_irq_delay.sv
// ========================================
// release lands 113..129 cycles late, the
// 2 MHz phase is free running
// ========================================

module sound_irq_delay (
	input  logic clk_32,
	input  logic xsint,		// async, active low
	input  logic snd_irq_i,		// dma sound interrupt, high active
	output logic timer_a_o		// inverted and delayed
);
	import st_audio_pkg::*;

	localparam int cnt_w = $clog2(ce2_div);

	logic [cnt_w-1:0]      div_q;	// free running
	logic                  ce2_q;	// one cycle in sixteen
	logic [irq_stages-1:0] dly_q;	// shift register, msb is the output

	// 2 MHz enable, registered so it is glitch free
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_q <= '0;
			ce2_q <= 1'b0;
		end else begin
			div_q <= div_q + 1'b1;	// wraps at ce2_div
			ce2_q <= (div_q == cnt_w'(ce2_div - 1));
		end
	end

	// clear while the interrupt is up, synchronous here
	// ones walk in once it drops
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			dly_q <= '0;
		end else if (snd_irq_i) begin
			dly_q <= '0;
		end else if (ce2_q) begin
			dly_q <= {dly_q[irq_stages-2:0], 1'b1};
		end
	end

	assign timer_a_o = dly_q[irq_stages-1];

	// the timer a input drops on the very next cycle
	a_irq_clears: assert property (@(posedge clk_32) disable iff (!xsint)
		snd_irq_i |=> !timer_a_o);

endmodule

// File: logic/st_audio.sv
// ========================================
// inputs in clk_32, 3 cycles to the dacs
// ========================================

module st_audio (
	input  logic                               clk_32,
	input  logic                               xsint,		// async, active low
	input  logic [st_audio_pkg::ym_level_w-1:0] ym_a_i,
	input  logic [st_audio_pkg::ym_level_w-1:0] ym_b_i,
	input  logic [st_audio_pkg::ym_level_w-1:0] ym_c_i,
	input  logic                               psg_stereo_i,
	input  st_audio_pkg::dma_stereo_t          dma_snd_i,	// offset binary
	input  logic                               snd_irq_i,
	output logic                               audio_l_o,
	output logic                               audio_r_o,
	output logic                               timer_a_o
);
	import st_audio_pkg::*;

	ym_stereo_t  ym_sum;	// registered psg sums
	mix_stereo_t ym_wide;
	mix_stereo_t dma_wide;
	mix_stereo_t mix;	// registered, saturated

	psg_channel_mix u_psg_mix (
		.clk_32       ( clk_32       ),
		.xsint        ( xsint        ),
		.ym_a_i       ( ym_a_i       ),
		.ym_b_i       ( ym_b_i       ),
		.ym_c_i       ( ym_c_i       ),
		.psg_stereo_i ( psg_stereo_i ),
		.ym_o         ( ym_sum       )
	);

	sample_expand #(.stereo_t(ym_stereo_t)) expand_ym (
		.pair_i ( ym_sum  ),
		.pair_o ( ym_wide )
	);

	// dma samples go straight in, shifter already holds them
	sample_expand #(.stereo_t(dma_stereo_t)) expand_dma (
		.pair_i ( dma_snd_i ),
		.pair_o ( dma_wide  )
	);

	audio_mixer u_mixer (
		.clk_32 ( clk_32   ),
		.xsint  ( xsint    ),
		.ym_i   ( ym_wide  ),
		.dma_i  ( dma_wide ),
		.mix_o  ( mix      )
	);

	sigma_delta_dac dac_l (
		.clk_32   ( clk_32    ),
		.xsint    ( xsint     ),
		.sample_i ( mix.left  ),
		.bit_o    ( audio_l_o )
	);

	sigma_delta_dac dac_r (
		.clk_32   ( clk_32    ),
		.xsint    ( xsint     ),
		.sample_i ( mix.right ),
		.bit_o    ( audio_r_o )
	);

	// separate from the audio chain, feeds mfp timer a
	sound_irq_delay u_irq_delay (
		.clk_32    ( clk_32    ),
		.xsint     ( xsint     ),
		.snd_irq_i ( snd_irq_i ),
		.timer_a_o ( timer_a_o )
	);

endmodule

// File: verif/st_audio_model.svh
// ========================================
// expected mix and bitstream density, kept
// in int arithmetic apart from the rtl
// ========================================

`ifndef ST_AUDIO_MODEL_SVH
`define ST_AUDIO_MODEL_SVH

// psg sum per side, stereo is a+b / c+b
function automatic int psg_left(input int a, input int b, input int c, input bit stereo);
	return stereo ? (a + b) : (a + b + c);
endfunction

function automatic int psg_right(input int a, input int b, input int c, input bit stereo);
	return stereo ? (c + b) : (a + b + c);
endfunction

// v is already signed, width is its field width
// result is v scaled up plus its own top bits underneath
function automatic int widen_model(input int v, input int width);
	int fill;
	int top;
	fill = mix_w - 1 - width;	// bits appended below
	top  = (v & ((1 << width) - 1)) >> (width - fill);	// raw pattern, top bits
	return v * (1 << fill) + top;
endfunction

// clamp to the 15-bit signed rails
function automatic int saturate(input int x);
	if (x > mix_max)
		return mix_max;
	if (x < mix_min)
		return mix_min;
	return x;
endfunction

// sign flip on a 15-bit value is the same as adding half scale
function automatic int dac_level(input int mix);
	return mix + (1 << (mix_w - 1));
endfunction

// ideal ones in a window, truncated
function automatic int expected_ones(input int u, input int window);
	return (u * window) / (1 << mix_w);
endfunction

`endif

// File: verif/st_audio_tb.sv
// ========================================
// one vector per 4104 cycles, density is
// checked to +-1 over a 4096 cycle window
// ========================================

module st_audio_tb;
	import st_audio_pkg::*;

	`include "st_audio_model.svh"

	localparam int window        = 4096;	// counted cycles per vector
	localparam int settle_cycles = 8;	// pipeline is 3 deep
	localparam int vec_cycles    = settle_cycles + window + 2;
	localparam int irq_budget    = 256;	// random wait, 20 high, up to 140 after
	localparam int max_cycles    = (13 * vec_cycles + irq_budget) * 11 / 10;
	localparam int rel_min       = 113;
	localparam int rel_max       = 129;

	logic        clk_32;
	logic        xsint;
	logic [7:0]  ym_a;
	logic [7:0]  ym_b;
	logic [7:0]  ym_c;
	logic        psg_stereo;
	dma_stereo_t dma_snd;
	logic        snd_irq;
	logic        audio_l;
	logic        audio_r;
	logic        timer_a;

	logic [31:0] seed = 32'h5d05;
	int          cycle_cnt = 0;
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          test_base;

	st_audio UUT (
		.clk_32       ( clk_32     ),
		.xsint        ( xsint      ),
		.ym_a_i       ( ym_a       ),
		.ym_b_i       ( ym_b       ),
		.ym_c_i       ( ym_c       ),
		.psg_stereo_i ( psg_stereo ),
		.dma_snd_i    ( dma_snd    ),
		.snd_irq_i    ( snd_irq    ),
		.audio_l_o    ( audio_l    ),
		.audio_r_o    ( audio_r    ),
		.timer_a_o    ( timer_a    )
	);

	initial begin
		clk_32 = 1'b0;
		forever #2 clk_32 = ~clk_32;	// period 4
	end

	always @(posedge clk_32) cycle_cnt <= cycle_cnt + 1;

	// watchdog
	initial begin
		wait (cycle_cnt >= max_cycles);
		$display("timeout: no result after %0d clock cycles, the run was stopped", cycle_cnt);
		$display("TEST FAIL");
		$finish;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;	// numerical recipes lcg
		return seed;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = next_random();
		return r[23:16];	// upper bits, better period
	endfunction

	// inputs change 1 unit after the edge, outputs are settled there too
	task automatic next_cycle();
		@(posedge clk_32);
		#1;
	endtask

	task automatic report_value(input string what, input int expected, input int measured);
		$display("** Error at %0t: %s expected %0d, measured %0d",
			$time, what, expected, measured);
		err_cnt++;
	endtask

	task automatic finish_test(input string name);
		$display("%s: done, %0d errors", name, err_cnt - test_base);
		test_base = err_cnt;
	endtask

	// hold one vector, let it settle, count both bitstreams
	task automatic run_vector(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c,
		input logic stereo, input logic [7:0] dl, input logic [7:0] dr);
		int exp_l;
		int exp_r;
		int ones_l;
		int ones_r;
		exp_l = expected_ones(dac_level(saturate(
			widen_model(psg_left(a, b, c, stereo) - ym_mid, ym_sum_w) +
			widen_model(int'(dl) - dma_mid, dma_w))), window);
		exp_r = expected_ones(dac_level(saturate(
			widen_model(psg_right(a, b, c, stereo) - ym_mid, ym_sum_w) +
			widen_model(int'(dr) - dma_mid, dma_w))), window);
		ym_a          = a;
		ym_b          = b;
		ym_c          = c;
		psg_stereo    = stereo;
		dma_snd.left  = dl;
		dma_snd.right = dr;
		repeat (settle_cycles) next_cycle();
		ones_l = 0;
		ones_r = 0;
		repeat (window) begin
			next_cycle();
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		check_cnt += 2;
		if (ones_l < exp_l - 1 || ones_l > exp_l + 1)
			report_value("left ones count", exp_l, ones_l);
		if (ones_r < exp_r - 1 || ones_r > exp_r + 1)
			report_value("right ones count", exp_r, ones_r);
		if (!stereo) begin
			check_cnt++;
			if (ones_l - ones_r > 1 || ones_r - ones_l > 1)
				report_value("mono right against left", ones_l, ones_r);	// sides differ
		end
	endtask

	initial begin
		int wait_cycles;
		int k;
		// quiet inputs, reset held
		xsint         = 1'b0;
		ym_a          = '0;
		ym_b          = '0;
		ym_c          = '0;
		psg_stereo    = 1'b0;
		dma_snd.left  = 8'd128;	// dma silence
		dma_snd.right = 8'd128;
		snd_irq       = 1'b0;
		test_base     = 0;

		// reset
		repeat (4) begin
			next_cycle();
			check_cnt++;
			if (audio_l || audio_r || timer_a)
				$display("** Error at %0t: output high during reset", $time);
			if (audio_l || audio_r || timer_a)
				err_cnt++;
		end
		xsint = 1'b1;
		next_cycle();
		check_cnt++;
		if (audio_l || audio_r || timer_a) begin
			$display("** Error at %0t: output high on the first cycle after reset", $time);
			err_cnt++;
		end
		finish_test("reset");

		// mono psg, dma at silence
		repeat (3) run_vector(rand_byte(), rand_byte(), rand_byte(), 1'b0, 8'd128, 8'd128);
		run_vector(8'd255, 8'd255, 8'd255, 1'b0, 8'd128, 8'd128);	// top corner
		finish_test("mono psg");

		// stereo psg
		repeat (4) run_vector(rand_byte(), rand_byte(), rand_byte(), 1'b1, 8'd128, 8'd128);
		finish_test("stereo psg");

		// dma mixed in, mode random too
		repeat (4) run_vector(rand_byte(), rand_byte(), rand_byte(), rand_byte() > 8'd127,
			rand_byte(), rand_byte());
		run_vector(8'd255, 8'd255, 8'd255, 1'b0, 8'd255, 8'd255);
		finish_test("dma mix");

		// interrupt delay, timer a long released by now
		wait_cycles = int'(rand_byte() % 8'd64);
		repeat (wait_cycles) next_cycle();
		check_cnt++;
		if (!timer_a)
			report_value("timer_a_o before the interrupt", 1, 0);
		snd_irq = 1'b1;
		next_cycle();
		check_cnt++;
		if (timer_a)
			report_value("timer_a_o one cycle after the rise", 0, 1);
		repeat (19) begin
			next_cycle();
			if (timer_a)
				report_value("timer_a_o while the interrupt is high", 0, 1);
		end
		snd_irq = 1'b0;
		k = 0;
		do begin
			next_cycle();
			k++;
		end while (!timer_a && k < rel_max + 11);
		check_cnt++;
		if (!timer_a) begin
			$display("** Error at %0t: timer_a_o still low %0d cycles after the fall",
				$time, k);
			err_cnt++;
		end else if (k < rel_min || k > rel_max) begin
			$display("** Error at %0t: timer_a_o rose %0d cycles after the fall, expected %0d..%0d",
				$time, k, rel_min, rel_max);
			err_cnt++;
		end
		finish_test("interrupt delay");

		$display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: st_audio.f
+incdir+verif
logic/st_audio_pkg.sv
logic/psg_channel_mix.sv
logic/sample_expand.sv
logic/audio_mixer.sv
logic/sigma_delta_dac.sv
logic/sound_irq_delay.sv
logic/st_audio.sv
verif/st_audio_tb.sv

// File: Makefile
# Verilator build and run of the st_audio testbench

SRCS := $(shell grep -v '^+' st_audio.f) verif/st_audio_model.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vst_audio_tb: st_audio.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module st_audio_tb -f st_audio.f

# the log decides pass or fail
run: obj_dir/Vst_audio_tb
	./obj_dir/Vst_audio_tb | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
